/* Makefile */
TOP = tb_usb_transactor

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f usb_transactor.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -c "All tests passed!" > /dev/null

clean:
	rm -rf obj_dir

/* rtl/usb_bulk_fsm.sv */
module usb_bulk_fsm (
  input  logic                    clock,
  input  logic                    reset,
  usb_bus_event_if.monitor        events,
  input  logic                    tok_addr_match_i,
  input  logic                    blk_in_ready_i,
  input  logic                    blk_out_ready_i,
  input  logic                    usb_tvalid_i,
  input  logic                    usb_tkeep_i,
  input  logic                    usb_tlast_i,
  input  logic [7:0]              usb_tdata_i,
  input  logic                    blk_tready_i,
  input  logic                    timeout_i,
  input  logic                    hsk_done_i,
  output usb_xact_pkg::err_code_t err_code_o,
  output logic                    blk_start_o,
  output logic                    blk_cycle_o,
  output logic [3:0]              blk_endpt_o,
  output logic                    blk_tvalid_o,
  output logic                    blk_tkeep_o,
  output logic                    blk_tlast_o,
  output logic [7:0]              blk_tdata_o,
  output logic                    usb_tready_o,
  output logic                    hsk_start_o,
  output logic                    hsk_nak_o,
  output logic                    toggle_flip_o,
  output logic                    timer_start_o,
  output logic                    tx_data_en_o,
  output logic                    tx_zdp_o,
  output logic                    tx_pid_load_o
);

  usb_xact_pkg::xact_state_t state_q;
  logic                      start_q;
  logic                      nak_q;
  logic [3:0]                endp_q;
  logic                      tok_hit;
  logic                      tok_bulk;
  logic                      endp_ok;
  logic                      tok_accept;
  logic                      out_last;
  logic                      in_acked;

  // Token addressed to this device
  assign tok_hit = events.tok_recv && tok_addr_match_i;
  assign tok_bulk = events.tok_type == usb_xact_pkg::TOK_IN ||
                    events.tok_type == usb_xact_pkg::TOK_OUT;
  assign endp_ok = events.tok_endp >= usb_xact_pkg::BULK_EP_FIRST &&
                   events.tok_endp <= usb_xact_pkg::BULK_EP_LAST;
  assign tok_accept = state_q == usb_xact_pkg::IDLE && tok_hit && tok_bulk && endp_ok;

  // Final OUT beat taken, whether forwarded or drained
  assign out_last = usb_tvalid_i && usb_tready_o && usb_tlast_i;
  assign in_acked = events.hsk_recv && events.hsk_type == usb_xact_pkg::HSK_ACK;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= usb_xact_pkg::IDLE;
      start_q <= 1'b0;
      nak_q <= 1'b0;
      err_code_o <= usb_xact_pkg::ERR_NONE;
    end else begin
      start_q <= tok_accept;
      case (state_q)
        usb_xact_pkg::IDLE: begin
          if (tok_hit) begin
            // Classify, then pick the data phase from endpoint readiness
            if (!tok_bulk) begin
              err_code_o <= usb_xact_pkg::ERR_TOKN;
            end else if (!endp_ok) begin
              err_code_o <= usb_xact_pkg::ERR_ENDP;
            end else begin
              err_code_o <= usb_xact_pkg::ERR_NONE;
              if (events.tok_type == usb_xact_pkg::TOK_IN) begin
                state_q <= blk_in_ready_i ? usb_xact_pkg::IN_TX : usb_xact_pkg::IN_ZDP;
              end else begin
                state_q <= blk_out_ready_i ? usb_xact_pkg::OUT_RX : usb_xact_pkg::OUT_DRAIN;
              end
            end
          end
        end
        usb_xact_pkg::IN_TX, usb_xact_pkg::IN_ZDP: begin
          if (events.usb_sent) begin
            state_q <= usb_xact_pkg::IN_WAIT_ACK;
          end
        end
        usb_xact_pkg::IN_WAIT_ACK: begin
          // Host answer, a lost answer, or the host moving on to a new token
          if (events.hsk_recv || timeout_i || events.tok_recv) begin
            state_q <= usb_xact_pkg::IDLE;
          end
        end
        usb_xact_pkg::OUT_RX, usb_xact_pkg::OUT_DRAIN: begin
          if (out_last) begin
            nak_q <= state_q == usb_xact_pkg::OUT_DRAIN;
            state_q <= usb_xact_pkg::OUT_HSK;
          end
        end
        usb_xact_pkg::OUT_HSK: begin
          if (hsk_done_i) begin
            state_q <= usb_xact_pkg::IDLE;
          end
        end
        default: begin
          state_q <= usb_xact_pkg::IDLE;
        end
      endcase
    end
  end

  // Endpoint of the accepted token
  always_ff @(posedge clock) begin
    if (tok_accept) begin
      endp_q <= events.tok_endp;
    end
  end

  assign blk_start_o = start_q;
  assign blk_cycle_o = state_q != usb_xact_pkg::IDLE;
  assign blk_endpt_o = endp_q;

  // OUT data goes straight to the sink, only while it is ready
  assign blk_tvalid_o = state_q == usb_xact_pkg::OUT_RX && usb_tvalid_i;
  assign blk_tkeep_o = usb_tkeep_i;
  assign blk_tlast_o = usb_tlast_i;
  assign blk_tdata_o = usb_tdata_i;
  assign usb_tready_o = state_q == usb_xact_pkg::OUT_RX ? blk_tready_i :
                        state_q == usb_xact_pkg::OUT_DRAIN;

  // Handshake after the end of an OUT packet
  assign hsk_start_o = (state_q == usb_xact_pkg::OUT_RX ||
                        state_q == usb_xact_pkg::OUT_DRAIN) && out_last;
  assign hsk_nak_o = state_q == usb_xact_pkg::OUT_DRAIN;

  // Toggle advances only on a successful data phase
  assign toggle_flip_o = (state_q == usb_xact_pkg::IN_WAIT_ACK && in_acked) ||
                         (state_q == usb_xact_pkg::OUT_HSK && hsk_done_i && !nak_q);

  // Turnaround timing starts when the IN packet leaves
  assign timer_start_o = (state_q == usb_xact_pkg::IN_TX ||
                          state_q == usb_xact_pkg::IN_ZDP) && events.usb_sent;

  // Transmit path steering
  assign tx_data_en_o = state_q == usb_xact_pkg::IN_TX;
  assign tx_zdp_o = start_q && state_q == usb_xact_pkg::IN_ZDP;
  assign tx_pid_load_o = start_q && (state_q == usb_xact_pkg::IN_TX ||
                                     state_q == usb_xact_pkg::IN_ZDP);

endmodule

/* rtl/usb_bus_event_if.sv */
interface usb_bus_event_if;

  // Token events from the decoder
  logic                    tok_recv;
  usb_xact_pkg::tok_type_t tok_type;
  logic [3:0]              tok_endp;

  // Handshake received from the host
  logic                    hsk_recv;
  usb_xact_pkg::hsk_type_t hsk_type;

  // Encoder finished a data packet
  logic                    usb_sent;

  modport monitor (
    input tok_recv,
    input tok_type,
    input tok_endp,
    input hsk_recv,
    input hsk_type,
    input usb_sent
  );

endinterface

/* rtl/usb_data_toggle.sv */
module usb_data_toggle (
  input  logic                    clock,
  input  logic                    reset,
  usb_bus_event_if.monitor        events,
  input  logic                    flip_i,
  output usb_xact_pkg::data_pid_t pid_o
);

  logic [usb_xact_pkg::ENDPOINT_COUNT-1:0] toggle_q;
  logic [3:0]                              endp_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      // Every endpoint starts on DATA0
      toggle_q <= '0;
      endp_q <= '0;
    end else begin
      if (events.tok_recv) begin
        endp_q <= events.tok_endp;
      end
      if (flip_i) begin
        toggle_q[endp_q] <= ~toggle_q[endp_q];
      end
    end
  end

  assign pid_o = toggle_q[endp_q] ? usb_xact_pkg::DATA1 : usb_xact_pkg::DATA0;

endmodule

/* rtl/usb_handshake_gen.sv */
module usb_handshake_gen (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    start_i,
  input  logic                    nak_i,
  input  logic                    hsk_sent_i,
  output logic                    hsk_send_o,
  output usb_xact_pkg::hsk_type_t hsk_type_o,
  output logic                    done_o
);

  localparam int CW = $clog2(usb_xact_pkg::EOP_DELAY + 1);

  logic [CW-1:0] delay_q;

  // Wait out the end of packet, then hold the request until the encoder sends it
  always_ff @(posedge clock) begin
    if (reset) begin
      delay_q <= '0;
      hsk_send_o <= 1'b0;
    end else begin
      if (start_i) begin
        delay_q <= CW'(usb_xact_pkg::EOP_DELAY);
      end else if (delay_q != '0) begin
        delay_q <= delay_q - 1'b1;
        if (delay_q == CW'(1)) begin
          hsk_send_o <= 1'b1;
        end
      end
      if (hsk_sent_i) begin
        hsk_send_o <= 1'b0;
      end
    end
  end

  // Kind is fixed for the whole request
  always_ff @(posedge clock) begin
    if (start_i) begin
      hsk_type_o <= nak_i ? usb_xact_pkg::HSK_NAK : usb_xact_pkg::HSK_ACK;
    end
  end

  assign done_o = hsk_send_o && hsk_sent_i;

endmodule

/* rtl/usb_transactor.sv */
module usb_transactor (
  input  logic       clock,
  input  logic       reset,
  input  logic [6:0] usb_addr_i,
  input  logic       tok_recv_i,
  input  logic [1:0] tok_type_i,
  input  logic [6:0] tok_addr_i,
  input  logic [3:0] tok_endp_i,
  input  logic       hsk_recv_i,
  input  logic [1:0] hsk_type_i,
  input  logic       hsk_sent_i,
  input  logic       usb_recv_i,
  input  logic       usb_sent_i,
  input  logic       usb_tvalid_i,
  input  logic       usb_tkeep_i,
  input  logic       usb_tlast_i,
  input  logic [7:0] usb_tdata_i,
  input  logic       blk_in_ready_i,
  input  logic       blk_out_ready_i,
  input  logic       blk_tvalid_i,
  input  logic       blk_tkeep_i,
  input  logic       blk_tlast_i,
  input  logic [7:0] blk_tdata_i,
  input  logic       usb_tready_i,
  input  logic       blk_tready_i,
  output logic [2:0] err_code_o,
  output logic       usb_timeout_error_o,
  output logic       hsk_send_o,
  output logic [1:0] hsk_type_o,
  output logic       usb_tready_o,
  output logic       blk_start_o,
  output logic       blk_cycle_o,
  output logic [3:0] blk_endpt_o,
  output logic       blk_tvalid_o,
  output logic       blk_tkeep_o,
  output logic       blk_tlast_o,
  output logic [7:0] blk_tdata_o,
  output logic       blk_tready_o,
  output logic       usb_tvalid_o,
  output logic       usb_tkeep_o,
  output logic       usb_tlast_o,
  output logic [7:0] usb_tdata_o,
  output logic [3:0] usb_tuser_o
);

  usb_bus_event_if bus_events ();

  usb_xact_pkg::err_code_t err_code;
  usb_xact_pkg::hsk_type_t hsk_type;
  usb_xact_pkg::data_pid_t pid;
  logic hsk_start;
  logic hsk_nak;
  logic hsk_done;
  logic toggle_flip;
  logic timer_start;
  logic tx_data_en;
  logic tx_zdp;
  logic tx_pid_load;

  // Decoder events onto the shared bundle
  assign bus_events.tok_recv = tok_recv_i;
  assign bus_events.tok_type = usb_xact_pkg::tok_type_t'(tok_type_i);
  assign bus_events.tok_endp = tok_endp_i;
  assign bus_events.hsk_recv = hsk_recv_i;
  assign bus_events.hsk_type = usb_xact_pkg::hsk_type_t'(hsk_type_i);
  assign bus_events.usb_sent = usb_sent_i;

  assign err_code_o = err_code;
  assign hsk_type_o = hsk_type;

  usb_bulk_fsm u_fsm (
    .clock            (clock),
    .reset            (reset),
    .events           (bus_events),
    .tok_addr_match_i (tok_addr_i == usb_addr_i),
    .blk_in_ready_i   (blk_in_ready_i),
    .blk_out_ready_i  (blk_out_ready_i),
    .usb_tvalid_i     (usb_tvalid_i),
    .usb_tkeep_i      (usb_tkeep_i),
    .usb_tlast_i      (usb_tlast_i),
    .usb_tdata_i      (usb_tdata_i),
    .blk_tready_i     (blk_tready_i),
    .timeout_i        (usb_timeout_error_o),
    .hsk_done_i       (hsk_done),
    .err_code_o       (err_code),
    .blk_start_o      (blk_start_o),
    .blk_cycle_o      (blk_cycle_o),
    .blk_endpt_o      (blk_endpt_o),
    .blk_tvalid_o     (blk_tvalid_o),
    .blk_tkeep_o      (blk_tkeep_o),
    .blk_tlast_o      (blk_tlast_o),
    .blk_tdata_o      (blk_tdata_o),
    .usb_tready_o     (usb_tready_o),
    .hsk_start_o      (hsk_start),
    .hsk_nak_o        (hsk_nak),
    .toggle_flip_o    (toggle_flip),
    .timer_start_o    (timer_start),
    .tx_data_en_o     (tx_data_en),
    .tx_zdp_o         (tx_zdp),
    .tx_pid_load_o    (tx_pid_load)
  );

  usb_turnaround_timer u_timer (
    .clock      (clock),
    .reset      (reset),
    .events     (bus_events),
    .usb_recv_i (usb_recv_i),
    .start_i    (timer_start),
    .timeout_o  (usb_timeout_error_o)
  );

  usb_handshake_gen u_hsk (
    .clock      (clock),
    .reset      (reset),
    .start_i    (hsk_start),
    .nak_i      (hsk_nak),
    .hsk_sent_i (hsk_sent_i),
    .hsk_send_o (hsk_send_o),
    .hsk_type_o (hsk_type),
    .done_o     (hsk_done)
  );

  usb_data_toggle u_toggle (
    .clock  (clock),
    .reset  (reset),
    .events (bus_events),
    .flip_i (toggle_flip),
    .pid_o  (pid)
  );

  usb_tx_path u_tx (
    .clock        (clock),
    .reset        (reset),
    .data_en_i    (tx_data_en),
    .zdp_i        (tx_zdp),
    .pid_load_i   (tx_pid_load),
    .pid_i        (pid),
    .blk_tvalid_i (blk_tvalid_i),
    .blk_tkeep_i  (blk_tkeep_i),
    .blk_tlast_i  (blk_tlast_i),
    .blk_tdata_i  (blk_tdata_i),
    .usb_tready_i (usb_tready_i),
    .blk_tready_o (blk_tready_o),
    .usb_tvalid_o (usb_tvalid_o),
    .usb_tkeep_o  (usb_tkeep_o),
    .usb_tlast_o  (usb_tlast_o),
    .usb_tdata_o  (usb_tdata_o),
    .usb_tuser_o  (usb_tuser_o)
  );

endmodule

/* rtl/usb_turnaround_timer.sv */
module usb_turnaround_timer (
  input  logic             clock,
  input  logic             reset,
  usb_bus_event_if.monitor events,
  input  logic             usb_recv_i,
  input  logic             start_i,
  output logic             timeout_o
);

  logic [usb_xact_pkg::TIMER_WIDTH-1:0] count_q;
  logic                                 active_q;
  logic                                 rx_event;

  // Anything from the host ends the wait
  assign rx_event = events.tok_recv || events.hsk_recv || usb_recv_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      count_q <= '0;
      active_q <= 1'b0;
      timeout_o <= 1'b0;
    end else begin
      if (start_i) begin
        count_q <= usb_xact_pkg::TIMER_WIDTH'(usb_xact_pkg::TURNAROUND_CYCLES);
        active_q <= 1'b1;
      end else if (rx_event) begin
        active_q <= 1'b0;
      end else if (active_q) begin
        count_q <= count_q - 1'b1;
        // Expires as the count reaches zero
        if (count_q == usb_xact_pkg::TIMER_WIDTH'(1)) begin
          active_q <= 1'b0;
          timeout_o <= 1'b1;
        end
      end
      // Error holds until the host sends another token
      if (events.tok_recv) begin
        timeout_o <= 1'b0;
      end
    end
  end

endmodule

/* rtl/usb_tx_path.sv */
module usb_tx_path (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    data_en_i,
  input  logic                    zdp_i,
  input  logic                    pid_load_i,
  input  usb_xact_pkg::data_pid_t pid_i,
  input  logic                    blk_tvalid_i,
  input  logic                    blk_tkeep_i,
  input  logic                    blk_tlast_i,
  input  logic [7:0]              blk_tdata_i,
  input  logic                    usb_tready_i,
  output logic                    blk_tready_o,
  output logic                    usb_tvalid_o,
  output logic                    usb_tkeep_o,
  output logic                    usb_tlast_o,
  output logic [7:0]              usb_tdata_o,
  output logic [3:0]              usb_tuser_o
);

  logic tail_q;
  logic blk_take;

  // Refill in the same cycle the register empties
  assign blk_tready_o = data_en_i && !tail_q && (!usb_tvalid_o || usb_tready_i);
  assign blk_take = blk_tvalid_i && blk_tready_o;

  always_ff @(posedge clock) begin
    if (reset) begin
      usb_tvalid_o <= 1'b0;
      tail_q <= 1'b0;
    end else begin
      if (blk_take || zdp_i) begin
        usb_tvalid_o <= 1'b1;
      end else if (usb_tready_i) begin
        usb_tvalid_o <= 1'b0;
      end
      // Stop taking beats once the packet's last one is in
      if (!data_en_i) begin
        tail_q <= 1'b0;
      end else if (blk_take && blk_tlast_i) begin
        tail_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (zdp_i) begin
      // Single empty beat closes a zero-data packet
      usb_tkeep_o <= 1'b0;
      usb_tlast_o <= 1'b1;
      usb_tdata_o <= '0;
    end else if (blk_take) begin
      usb_tkeep_o <= blk_tkeep_i;
      usb_tlast_o <= blk_tlast_i;
      usb_tdata_o <= blk_tdata_i;
    end
    if (pid_load_i) begin
      usb_tuser_o <= {pid_i, usb_xact_pkg::DATA_PKT_TAG};
    end
  end

endmodule

/* rtl/usb_xact_pkg.sv */
package usb_xact_pkg;

  // Token PIDs as delivered by the packet decoder
  typedef enum logic [1:0] {
    TOK_OUT   = 2'b00,
    TOK_SOF   = 2'b01,
    TOK_IN    = 2'b10,
    TOK_SETUP = 2'b11
  } tok_type_t;

  // Handshake kinds, only ACK and NAK are issued by this device
  typedef enum logic [1:0] {
    HSK_ACK = 2'b00,
    HSK_NAK = 2'b10
  } hsk_type_t;

  // Data packet kinds
  typedef enum logic [1:0] {
    DATA0 = 2'b00,
    DATA1 = 2'b10
  } data_pid_t;

  // Token dispatch result
  typedef enum logic [2:0] {
    ERR_NONE = 3'h0,
    ERR_TOKN = 3'h3,
    ERR_ENDP = 3'h5
  } err_code_t;

  // Bulk transaction sequencing
  typedef enum logic [2:0] {
    IDLE,
    IN_TX,
    IN_ZDP,
    IN_WAIT_ACK,
    OUT_RX,
    OUT_DRAIN,
    OUT_HSK
  } xact_state_t;

  // Low PID bits that mark a data packet for the encoder
  localparam logic [1:0] DATA_PKT_TAG = 2'b11;

  // Endpoints served as bulk
  localparam logic [3:0] BULK_EP_FIRST = 4'd1;
  localparam logic [3:0] BULK_EP_LAST = 4'd3;
  localparam int ENDPOINT_COUNT = 16;

  // Timing, in clock cycles
  localparam int EOP_DELAY = 5;
  localparam int TURNAROUND_CYCLES = 255;
  localparam int TIMER_WIDTH = 8;

endpackage

/* testbench/tb_usb_transactor.sv */
module tb_usb_transactor;

  localparam logic [31:0] SEED = 32'd3868;
  localparam logic [6:0] DEV_ADDR = 7'h2a;
  localparam logic [6:0] OTHER_ADDR = 7'h2b;
  localparam int LEN_MAX = 8;
  localparam int ROW_COUNT = 15;
  localparam int XFER_LIMIT = 400;
  localparam int HSK_LIMIT = 20;
  // Low PID bits of a data packet
  localparam logic [1:0] DATA_TAG = 2'b11;

  // One bulk transaction and what the device should do with it
  typedef struct {
    logic [1:0] tok;
    logic [6:0] addr;
    logic [3:0] endp;
    logic       ready;
    int         len;
    logic       answer;
    logic [2:0] err;
    logic [1:0] pid;
    logic [1:0] hsk;
  } xact_row_t;

  logic       clock;
  logic       reset;
  logic [6:0] usb_addr_i;
  logic       tok_recv_i;
  logic [1:0] tok_type_i;
  logic [6:0] tok_addr_i;
  logic [3:0] tok_endp_i;
  logic       hsk_recv_i;
  logic [1:0] hsk_type_i;
  logic       hsk_sent_i;
  logic       usb_recv_i;
  logic       usb_sent_i;
  logic       usb_tvalid_i;
  logic       usb_tkeep_i;
  logic       usb_tlast_i;
  logic [7:0] usb_tdata_i;
  logic       blk_in_ready_i;
  logic       blk_out_ready_i;
  logic       blk_tvalid_i;
  logic       blk_tkeep_i;
  logic       blk_tlast_i;
  logic [7:0] blk_tdata_i;
  logic       usb_tready_i;
  logic       blk_tready_i;
  logic [2:0] err_code_o;
  logic       usb_timeout_error_o;
  logic       hsk_send_o;
  logic [1:0] hsk_type_o;
  logic       usb_tready_o;
  logic       blk_start_o;
  logic       blk_cycle_o;
  logic [3:0] blk_endpt_o;
  logic       blk_tvalid_o;
  logic       blk_tkeep_o;
  logic       blk_tlast_o;
  logic [7:0] blk_tdata_o;
  logic       blk_tready_o;
  logic       usb_tvalid_o;
  logic       usb_tkeep_o;
  logic       usb_tlast_o;
  logic [7:0] usb_tdata_o;
  logic [3:0] usb_tuser_o;

  xact_row_t   rows [ROW_COUNT];
  logic [7:0]  payload [LEN_MAX];
  logic [31:0] rng_state;

  usb_transactor i_dut (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Xorshift32 step
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic stop_run();
    $display("Test failures found");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
    if (got !== expected) begin
      $display("[FAIL] t=%0t %s got=%0h expected=%0h", $time, name, got, expected);
      stop_run();
    end
  endtask

  task automatic give_up(input string what);
    $display("Timeout: %s", what);
    stop_run();
  endtask

  task automatic init_inputs();
    reset = 1'b1;
    usb_addr_i = DEV_ADDR;
    tok_recv_i = 1'b0;
    tok_type_i = '0;
    tok_addr_i = '0;
    tok_endp_i = '0;
    hsk_recv_i = 1'b0;
    hsk_type_i = '0;
    hsk_sent_i = 1'b0;
    usb_recv_i = 1'b0;
    usb_sent_i = 1'b0;
    usb_tvalid_i = 1'b0;
    usb_tkeep_i = 1'b0;
    usb_tlast_i = 1'b0;
    usb_tdata_i = '0;
    blk_in_ready_i = 1'b0;
    blk_out_ready_i = 1'b0;
    blk_tvalid_i = 1'b0;
    blk_tkeep_i = 1'b0;
    blk_tlast_i = 1'b0;
    blk_tdata_i = '0;
    usb_tready_i = 1'b0;
    blk_tready_i = 1'b0;
  endtask

  // Columns: token, address, endpoint, source/sink ready, length, host answers,
  // error code, PID of the IN packet, handshake of the OUT packet
  task automatic load_table();
    rows[0] = '{usb_xact_pkg::TOK_IN, DEV_ADDR, 4'd1, 1'b1, 5, 1'b1,
                usb_xact_pkg::ERR_NONE, usb_xact_pkg::DATA0, usb_xact_pkg::HSK_ACK};
    rows[1] = '{usb_xact_pkg::TOK_IN, DEV_ADDR, 4'd1, 1'b1, 3, 1'b1,
                usb_xact_pkg::ERR_NONE, usb_xact_pkg::DATA1, usb_xact_pkg::HSK_ACK};
    rows[2] = '{usb_xact_pkg::TOK_IN, DEV_ADDR, 4'd1, 1'b0, 0, 1'b1,
                usb_xact_pkg::ERR_NONE, usb_xact_pkg::DATA0, usb_xact_pkg::HSK_ACK};
    rows[3] = '{usb_xact_pkg::TOK_OUT, DEV_ADDR, 4'd2, 1'b1, 6, 1'b1,
                usb_xact_pkg::ERR_NONE, usb_xact_pkg::DATA0, usb_xact_pkg::HSK_ACK};
    rows[4] = '{usb_xact_pkg::TOK_IN, DEV_ADDR, 4'd2, 1'b0, 0, 1'b1,
                usb_xact_pkg::ERR_NONE, usb_xact_pkg::DATA1, usb_xact_pkg::HSK_ACK};
    rows[5] = '{usb_xact_pkg::TOK_OUT, DEV_ADDR, 4'd3, 1'b0, 4, 1'b1,
                usb_xact_pkg::ERR_NONE, usb_xact_pkg::DATA0, usb_xact_pkg::HSK_NAK};
    rows[6] = '{usb_xact_pkg::TOK_IN, DEV_ADDR, 4'd3, 1'b1, 2, 1'b1,
                usb_xact_pkg::ERR_NONE, usb_xact_pkg::DATA0, usb_xact_pkg::HSK_ACK};
    rows[7] = '{usb_xact_pkg::TOK_SETUP, DEV_ADDR, 4'd0, 1'b0, 0, 1'b0,
                usb_xact_pkg::ERR_TOKN, usb_xact_pkg::DATA0, usb_xact_pkg::HSK_ACK};
    // Foreign address keeps the previous code
    rows[8] = '{usb_xact_pkg::TOK_IN, OTHER_ADDR, 4'd1, 1'b1, 3, 1'b1,
                usb_xact_pkg::ERR_TOKN, usb_xact_pkg::DATA0, usb_xact_pkg::HSK_ACK};
    rows[9] = '{usb_xact_pkg::TOK_IN, DEV_ADDR, 4'd0, 1'b1, 3, 1'b1,
                usb_xact_pkg::ERR_ENDP, usb_xact_pkg::DATA0, usb_xact_pkg::HSK_ACK};
    rows[10] = '{usb_xact_pkg::TOK_IN, DEV_ADDR, 4'd5, 1'b1, 3, 1'b1,
                 usb_xact_pkg::ERR_ENDP, usb_xact_pkg::DATA0, usb_xact_pkg::HSK_ACK};
    // Lost handshake, toggle of endpoint 1 must survive
    rows[11] = '{usb_xact_pkg::TOK_IN, DEV_ADDR, 4'd1, 1'b1, 4, 1'b0,
                 usb_xact_pkg::ERR_NONE, usb_xact_pkg::DATA1, usb_xact_pkg::HSK_ACK};
    rows[12] = '{usb_xact_pkg::TOK_IN, DEV_ADDR, 4'd1, 1'b1, 1, 1'b1,
                 usb_xact_pkg::ERR_NONE, usb_xact_pkg::DATA1, usb_xact_pkg::HSK_ACK};
    rows[13] = '{usb_xact_pkg::TOK_OUT, DEV_ADDR, 4'd1, 1'b1, 8, 1'b1,
                 usb_xact_pkg::ERR_NONE, usb_xact_pkg::DATA0, usb_xact_pkg::HSK_ACK};
    rows[14] = '{usb_xact_pkg::TOK_IN, DEV_ADDR, 4'd1, 1'b0, 0, 1'b1,
                 usb_xact_pkg::ERR_NONE, usb_xact_pkg::DATA1, usb_xact_pkg::HSK_ACK};
  endtask

  task automatic fill_payload();
    logic [31:0] r;
    for (int k = 0; k < LEN_MAX; k++) begin
      r = next_random();
      payload[k] = r[7:0];
    end
  endtask

  // Token pulse, then the dispatch result one cycle later
  task automatic send_token(input xact_row_t row, input logic accepted);
    @(negedge clock);
    tok_recv_i = 1'b1;
    tok_type_i = row.tok;
    tok_addr_i = row.addr;
    tok_endp_i = row.endp;
    @(negedge clock);
    tok_recv_i = 1'b0;
    check("blk_start_o", 32'(blk_start_o), 32'(accepted));
    check("blk_cycle_o", 32'(blk_cycle_o), 32'(accepted));
    check("err_code_o", 32'(err_code_o), 32'(row.err));
    check("usb_timeout_error_o", 32'(usb_timeout_error_o), 32'(1'b0));
    if (accepted) begin
      check("blk_endpt_o", 32'(blk_endpt_o), 32'(row.endp));
    end
  endtask

  // Rejected token, nothing may start
  task automatic watch_idle();
    repeat (3) begin
      @(negedge clock);
      check("blk_start_o", 32'(blk_start_o), 32'(1'b0));
      check("blk_cycle_o", 32'(blk_cycle_o), 32'(1'b0));
    end
  endtask

  // Bulk IN source feeding the device, encoder side with random stalls
  task automatic run_in(input xact_row_t row);
    logic [31:0] r;
    int          src_idx;
    int          sink_idx;
    int          beats;
    int          cycles;
    fill_payload();
    src_idx = 0;
    sink_idx = 0;
    cycles = 0;
    beats = row.ready ? row.len : 1;
    while (sink_idx < beats) begin
      r = next_random();
      usb_tready_i = r[1:0] != 2'b00;
      blk_tvalid_i = row.ready && src_idx < row.len;
      blk_tkeep_i = 1'b1;
      blk_tlast_i = src_idx == row.len - 1;
      if (src_idx < row.len) begin
        blk_tdata_i = payload[src_idx];
      end
      @(posedge clock);
      if (!row.ready) begin
        check("blk_tready_o", 32'(blk_tready_o), 32'(1'b0));
      end
      if (blk_tvalid_i && blk_tready_o) begin
        src_idx++;
      end
      if (usb_tvalid_o && usb_tready_i) begin
        if (row.ready) begin
          check("usb_tdata_o", 32'(usb_tdata_o), 32'(payload[sink_idx]));
        end
        check("usb_tkeep_o", 32'(usb_tkeep_o), 32'(row.ready));
        check("usb_tlast_o", 32'(usb_tlast_o), 32'(sink_idx == beats - 1));
        check("usb_tuser_o", 32'(usb_tuser_o), 32'({row.pid, DATA_TAG}));
        sink_idx++;
      end
      @(negedge clock);
      cycles++;
      if (cycles > XFER_LIMIT) begin
        give_up("bulk IN packet did not complete on the encoder stream");
      end
    end
    blk_tvalid_i = 1'b0;
    blk_tlast_i = 1'b0;
    usb_tready_i = 1'b1;
    // Exactly one packet worth of beats, register drained
    check("usb_tvalid_o", 32'(usb_tvalid_o), 32'(1'b0));
    check("source beats taken", 32'(src_idx), 32'(row.ready ? row.len : 0));
  endtask

  // Packet sent, then an ACK from the host or silence until the timer expires
  task automatic finish_in(input xact_row_t row);
    logic [31:0] r;
    int          waited;
    usb_sent_i = 1'b1;
    @(negedge clock);
    usb_sent_i = 1'b0;
    if (row.answer) begin
      r = next_random();
      repeat (r[2:0]) @(negedge clock);
      check("blk_cycle_o", 32'(blk_cycle_o), 32'(1'b1));
      hsk_recv_i = 1'b1;
      hsk_type_i = usb_xact_pkg::HSK_ACK;
      @(negedge clock);
      hsk_recv_i = 1'b0;
      check("blk_cycle_o", 32'(blk_cycle_o), 32'(1'b0));
    end else begin
      waited = 0;
      while (!usb_timeout_error_o) begin
        @(negedge clock);
        waited++;
        if (waited > usb_xact_pkg::TURNAROUND_CYCLES + 1) begin
          give_up("usb_timeout_error_o did not rise after an unanswered IN packet");
        end
      end
      @(negedge clock);
      check("blk_cycle_o", 32'(blk_cycle_o), 32'(1'b0));
      check("usb_timeout_error_o", 32'(usb_timeout_error_o), 32'(1'b1));
    end
  endtask

  // Host sends an OUT packet, sink applies random back-pressure
  task automatic run_out(input xact_row_t row);
    logic [31:0] r;
    int          host_idx;
    int          sink_idx;
    int          cycles;
    int          waited;
    fill_payload();
    host_idx = 0;
    sink_idx = 0;
    cycles = 0;
    while (host_idx < row.len) begin
      r = next_random();
      blk_tready_i = r[1:0] != 2'b00;
      usb_tvalid_i = 1'b1;
      usb_tkeep_i = 1'b1;
      usb_tlast_i = host_idx == row.len - 1;
      usb_tdata_i = payload[host_idx];
      @(posedge clock);
      if (row.ready) begin
        check("usb_tready_o", 32'(usb_tready_o), 32'(blk_tready_i));
      end else begin
        check("usb_tready_o", 32'(usb_tready_o), 32'(1'b1));
        check("blk_tvalid_o", 32'(blk_tvalid_o), 32'(1'b0));
      end
      if (blk_tvalid_o && blk_tready_i) begin
        check("blk_tdata_o", 32'(blk_tdata_o), 32'(payload[sink_idx]));
        check("blk_tkeep_o", 32'(blk_tkeep_o), 32'(1'b1));
        check("blk_tlast_o", 32'(blk_tlast_o), 32'(sink_idx == row.len - 1));
        sink_idx++;
      end
      if (usb_tvalid_i && usb_tready_o) begin
        host_idx++;
      end
      @(negedge clock);
      cycles++;
      if (cycles > XFER_LIMIT) begin
        give_up("bulk OUT packet was not accepted by the device");
      end
    end
    usb_tvalid_i = 1'b0;
    usb_tlast_i = 1'b0;
    blk_tready_i = 1'b0;
    check("sink beats", 32'(sink_idx), 32'(row.ready ? row.len : 0));
    // Handshake request after the end-of-packet delay
    waited = 0;
    while (!hsk_send_o) begin
      @(posedge clock);
      waited++;
      if (waited > HSK_LIMIT) begin
        give_up("hsk_send_o did not rise after the OUT packet");
      end
    end
    check("hsk_send_o delay", 32'(waited), 32'(usb_xact_pkg::EOP_DELAY + 1));
    @(negedge clock);
    r = next_random();
    repeat (r[1:0]) begin
      check("hsk_send_o", 32'(hsk_send_o), 32'(1'b1));
      check("hsk_type_o", 32'(hsk_type_o), 32'(row.hsk));
      @(negedge clock);
    end
    check("hsk_type_o", 32'(hsk_type_o), 32'(row.hsk));
    hsk_sent_i = 1'b1;
    @(negedge clock);
    hsk_sent_i = 1'b0;
    check("hsk_send_o", 32'(hsk_send_o), 32'(1'b0));
    check("blk_cycle_o", 32'(blk_cycle_o), 32'(1'b0));
  endtask

  initial begin
    xact_row_t row;
    logic      accepted;
    init_inputs();
    rng_state = SEED;
    load_table();
    repeat (10) @(posedge clock);
    @(negedge clock);
    // Reset values
    check("blk_start_o", 32'(blk_start_o), 32'(1'b0));
    check("blk_cycle_o", 32'(blk_cycle_o), 32'(1'b0));
    check("hsk_send_o", 32'(hsk_send_o), 32'(1'b0));
    check("usb_tvalid_o", 32'(usb_tvalid_o), 32'(1'b0));
    check("blk_tvalid_o", 32'(blk_tvalid_o), 32'(1'b0));
    check("blk_tready_o", 32'(blk_tready_o), 32'(1'b0));
    check("usb_timeout_error_o", 32'(usb_timeout_error_o), 32'(1'b0));
    check("err_code_o", 32'(err_code_o), 32'(usb_xact_pkg::ERR_NONE));
    reset = 1'b0;
    for (int i = 0; i < ROW_COUNT; i++) begin
      row = rows[i];
      accepted = row.addr == DEV_ADDR && row.err == usb_xact_pkg::ERR_NONE;
      // Endpoint readiness is sampled with the token
      blk_in_ready_i = row.tok == usb_xact_pkg::TOK_IN && row.ready;
      blk_out_ready_i = row.tok == usb_xact_pkg::TOK_OUT && row.ready;
      send_token(row, accepted);
      if (!accepted) begin
        watch_idle();
      end else if (row.tok == usb_xact_pkg::TOK_IN) begin
        run_in(row);
        finish_in(row);
      end else begin
        run_out(row);
      end
      repeat (2) @(negedge clock);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

/* testbench/usb_transactor_properties.sv */
module usb_transactor_properties (
  input logic                      clock,
  input logic                      reset,
  input usb_xact_pkg::xact_state_t state_i,
  input logic                      blk_start_i,
  input logic                      blk_cycle_i,
  input logic                      hsk_start_i
);

  // Start marker is a single pulse
  a_start_pulse: assert property (@(posedge clock) disable iff (reset)
    blk_start_i |=> !blk_start_i)
    else $error("blk_start_o stayed high for more than one cycle");

  // Handshake only closes an OUT data phase, and the FSM then waits for it
  a_hsk_in_out: assert property (@(posedge clock) disable iff (reset)
    hsk_start_i |=> state_i == usb_xact_pkg::OUT_HSK)
    else $error("hsk_start_o outside the OUT states");

  // Start marks the first busy cycle after an idle FSM
  a_idle_cycle: assert property (@(posedge clock) disable iff (reset)
    blk_start_i |-> blk_cycle_i && $past(state_i) == usb_xact_pkg::IDLE)
    else $error("blk_cycle_o high while the FSM is idle");

endmodule

bind usb_bulk_fsm usb_transactor_properties i_properties (
  .clock       (clock),
  .reset       (reset),
  .state_i     (state_q),
  .blk_start_i (blk_start_o),
  .blk_cycle_i (blk_cycle_o),
  .hsk_start_i (hsk_start_o)
);

/* usb_transactor.f */
rtl/usb_xact_pkg.sv
rtl/usb_bus_event_if.sv
rtl/usb_bulk_fsm.sv
rtl/usb_turnaround_timer.sv
rtl/usb_handshake_gen.sv
rtl/usb_data_toggle.sv
rtl/usb_tx_path.sv
rtl/usb_transactor.sv
testbench/usb_transactor_properties.sv
testbench/tb_usb_transactor.sv
